// File: imuldiv_op_pkg.sv
// operation encodings and data types for the multiply/divide unit
// shared by the request and response ports of every block

package imuldiv_op_pkg;

  //--------------------------------------------------------------------------
  // widths
  //--------------------------------------------------------------------------

  // machine word width of the attached pipeline
  localparam int xlen = 32;

  //--------------------------------------------------------------------------
  // types
  //--------------------------------------------------------------------------

  // one source operand
  typedef logic [xlen-1:0] operand_t;

  // full-width result
  // product for mul, {remainder, quotient} for the divides
  typedef logic [2*xlen-1:0] result_t;

  // request opcode
  // op_div and op_divu share the divider, op_mul goes to the multiplier
  typedef enum logic [1:0] {
    op_mul  = 2'd0,
    op_div  = 2'd1,
    op_divu = 2'd2
  } muldiv_op_t;

endpackage

// File: imuldiv_ctrl_pkg.sv
// control definitions shared by the iterative multiply and divide units
// FSM states and the length of the bit-serial calc phase

package imuldiv_ctrl_pkg;

  // idle waits for a request, calc runs one bit per cycle,
  // done holds the result until the response transfers
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } iter_state_t;

  // number of cycles spent in st_calc, one per operand bit
  localparam int iter_count = 32;

  // iteration counter width, room for 0 .. iter_count
  localparam int count_w = 6;

endpackage

// File: imuldiv_mul_iterative.sv
// iterative signed multiplier, 32 x 32 -> 64
// shift-add over the operand magnitudes, sign applied to the product at the end
`timescale 1ns/1ns

module imuldiv_mul_iterative (
  input  logic                     clk,
  input  logic                     reset,
  input  imuldiv_op_pkg::operand_t req_a,
  input  imuldiv_op_pkg::operand_t req_b,
  input  logic                     req_val,
  output logic                     req_rdy,
  output imuldiv_op_pkg::result_t  resp_result,
  output logic                     resp_val,
  input  logic                     resp_rdy
);

  import imuldiv_op_pkg::*;
  import imuldiv_ctrl_pkg::*;

  //--------------------------------------------------------------------------
  // control
  //--------------------------------------------------------------------------

  iter_state_t        state;
  logic [count_w-1:0] count;
  logic               req_go;
  logic               resp_go;
  // load selects the initial operand values, step the shifted ones
  logic               dp_load;
  logic               dp_step;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_go) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          // last bit this cycle
          if (count == count_w'(iter_count - 1)) begin
            state <= st_done;
          end else begin
            count <= count + count_w'(1);
          end
        end
        st_done: begin
          // hold the result until the consumer takes it
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  always_comb begin
    req_rdy  = 1'b0;
    resp_val = 1'b0;
    dp_load  = 1'b0;
    dp_step  = 1'b0;
    case (state)
      st_idle: begin
        req_rdy = 1'b1;
        dp_load = req_val;
      end
      st_calc: begin
        dp_step = 1'b1;
      end
      st_done: begin
        resp_val = 1'b1;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

  //--------------------------------------------------------------------------
  // datapath
  //--------------------------------------------------------------------------

  result_t  mcand;
  operand_t mplier;
  result_t  acc;
  logic     neg_result;
  operand_t a_mag;
  operand_t b_mag;

  // two's complement magnitudes of the request operands
  assign a_mag = req_a[xlen-1] ? (~req_a + 1'b1) : req_a;
  assign b_mag = req_b[xlen-1] ? (~req_b + 1'b1) : req_b;

  always_ff @(posedge clk) begin
    if (dp_load) begin
      mcand      <= {{xlen{1'b0}}, a_mag};
      mplier     <= b_mag;
      acc        <= '0;
      // product is negative when exactly one operand is
      neg_result <= req_a[xlen-1] ^ req_b[xlen-1];
    end else if (dp_step) begin
      // add the current multiplicand weight for each set multiplier bit
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  assign resp_result = neg_result ? (~acc + 1'b1) : acc;

  //--------------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------------

  // a new request is never offered while a result is pending
  a_rdy_val_excl: assert property (@(posedge clk) disable iff (reset)
    !(req_rdy && resp_val));

  a_count_range: assert property (@(posedge clk) disable iff (reset)
    (state == st_calc) |-> (count <= count_w'(iter_count - 1)));

endmodule

// File: imuldiv_div_iterative.sv
// iterative restoring divider, signed and unsigned 32-bit
// result is {remainder, quotient}, signs applied after the last step
`timescale 1ns/1ns

module imuldiv_div_iterative (
  input  logic                       clk,
  input  logic                       reset,
  input  imuldiv_op_pkg::muldiv_op_t req_op,
  input  imuldiv_op_pkg::operand_t   req_a,
  input  imuldiv_op_pkg::operand_t   req_b,
  input  logic                       req_val,
  output logic                       req_rdy,
  output imuldiv_op_pkg::result_t    resp_result,
  output logic                       resp_val,
  input  logic                       resp_rdy
);

  import imuldiv_op_pkg::*;
  import imuldiv_ctrl_pkg::*;

  //--------------------------------------------------------------------------
  // control
  //--------------------------------------------------------------------------

  iter_state_t        state;
  logic [count_w-1:0] count;
  logic               req_go;
  logic               resp_go;
  logic               dp_load;
  logic               dp_step;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_go) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          if (count == count_w'(iter_count - 1)) begin
            state <= st_done;
          end else begin
            count <= count + count_w'(1);
          end
        end
        st_done: begin
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  always_comb begin
    req_rdy  = 1'b0;
    resp_val = 1'b0;
    dp_load  = 1'b0;
    dp_step  = 1'b0;
    case (state)
      st_idle: begin
        req_rdy = 1'b1;
        dp_load = req_val;
      end
      st_calc: begin
        dp_step = 1'b1;
      end
      st_done: begin
        resp_val = 1'b1;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

  //--------------------------------------------------------------------------
  // datapath
  //--------------------------------------------------------------------------

  // upper word partial remainder, lower word dividend bits then quotient
  result_t       rq;
  operand_t      dvsr_mag;
  logic          neg_quot;
  logic          neg_rem;
  logic          a_neg;
  logic          b_neg;
  operand_t      a_mag;
  operand_t      b_mag;
  logic [xlen:0] rem_shift;
  logic [xlen:0] rem_diff;
  logic          sub_ok;
  operand_t      quot_out;
  operand_t      rem_out;

  // op_divu keeps the raw operands
  assign a_neg = (req_op == op_div) && req_a[xlen-1];
  assign b_neg = (req_op == op_div) && req_b[xlen-1];
  assign a_mag = a_neg ? (~req_a + 1'b1) : req_a;
  assign b_mag = b_neg ? (~req_b + 1'b1) : req_b;

  // remainder after the left shift, one extra bit so large divisors fit
  assign rem_shift = rq[2*xlen-1:xlen-1];
  // trial subtract, keep it only when it does not go negative
  assign rem_diff  = rem_shift - {1'b0, dvsr_mag};
  assign sub_ok    = (rem_shift >= {1'b0, dvsr_mag});

  always_ff @(posedge clk) begin
    if (dp_load) begin
      rq       <= {{xlen{1'b0}}, a_mag};
      dvsr_mag <= b_mag;
      // a zero divisor leaves the all-ones quotient positive
      neg_quot <= (a_neg ^ b_neg) && (req_b != '0);
      neg_rem  <= a_neg;
    end else if (dp_step) begin
      if (sub_ok) begin
        rq <= {rem_diff[xlen-1:0], rq[xlen-2:0], 1'b1};
      end else begin
        rq <= {rem_shift[xlen-1:0], rq[xlen-2:0], 1'b0};
      end
    end
  end

  // quotient takes the xor of the signs, remainder follows the dividend
  assign quot_out    = neg_quot ? (~rq[xlen-1:0] + 1'b1) : rq[xlen-1:0];
  assign rem_out     = neg_rem ? (~rq[2*xlen-1:xlen] + 1'b1) : rq[2*xlen-1:xlen];
  assign resp_result = {rem_out, quot_out};

  //--------------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------------

  a_rdy_val_excl: assert property (@(posedge clk) disable iff (reset)
    !(req_rdy && resp_val));

  a_count_range: assert property (@(posedge clk) disable iff (reset)
    (state == st_calc) |-> (count <= count_w'(iter_count - 1)));

  // result must not move while the consumer stalls
  a_result_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> $stable(resp_result));

endmodule

// File: imuldiv_muldiv.sv
// multiply/divide unit top, one operation in flight at a time
// steers each request by opcode and merges the two result streams
`timescale 1ns/1ns

module imuldiv_muldiv (
  input  logic                       clk,
  input  logic                       reset,
  input  imuldiv_op_pkg::muldiv_op_t req_op,
  input  imuldiv_op_pkg::operand_t   req_a,
  input  imuldiv_op_pkg::operand_t   req_b,
  input  logic                       req_val,
  output logic                       req_rdy,
  output imuldiv_op_pkg::result_t    resp_result,
  output logic                       resp_val,
  input  logic                       resp_rdy
);

  import imuldiv_op_pkg::*;

  logic    mul_req_val;
  logic    mul_req_rdy;
  logic    mul_resp_val;
  result_t mul_resp_result;
  logic    div_req_val;
  logic    div_req_rdy;
  logic    div_resp_val;
  result_t div_resp_result;

  //--------------------------------------------------------------------------
  // request steering
  //--------------------------------------------------------------------------

  // each unit only sees a valid when the other one is idle too,
  // so a unit never accepts while the top reports not ready
  assign mul_req_val = req_val && div_req_rdy && (req_op == op_mul);
  assign div_req_val = req_val && mul_req_rdy &&
                       ((req_op == op_div) || (req_op == op_divu));
  assign req_rdy     = mul_req_rdy && div_req_rdy;

  imuldiv_mul_iterative u_mul (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (mul_req_val),
    .req_rdy     (mul_req_rdy),
    .resp_result (mul_resp_result),
    .resp_val    (mul_resp_val),
    .resp_rdy    (resp_rdy)
  );

  imuldiv_div_iterative u_div (
    .clk         (clk),
    .reset       (reset),
    .req_op      (req_op),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (div_req_val),
    .req_rdy     (div_req_rdy),
    .resp_result (div_resp_result),
    .resp_val    (div_resp_val),
    .resp_rdy    (resp_rdy)
  );

  //--------------------------------------------------------------------------
  // response merge
  //--------------------------------------------------------------------------

  assign resp_val    = mul_resp_val || div_resp_val;
  assign resp_result = div_resp_val ? div_resp_result : mul_resp_result;

  // single operation in flight, so at most one unit holds a result
  a_one_resp: assert property (@(posedge clk) disable iff (reset)
    !(mul_resp_val && div_resp_val));

endmodule

// File: tb_clock_gen.sv
// testbench clock and reset source
// 20 ns clock, reset held high for the first two rising edges
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  localparam int half_period = 10;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // released on the second edge, so the DUT sees two reset cycles
  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// File: tb_imuldiv.sv
// testbench for the multiply/divide unit
// table of requests with expected results, random response back-pressure
`timescale 1ns/1ns

module tb_imuldiv;

  import imuldiv_op_pkg::*;

  localparam int timeout_cycles = 100;
  // edges from the accept edge (counted as the first) to the resp_val rise
  localparam int resp_latency   = 33;
  localparam int random_entries = 40;
  localparam int max_stall      = 5;

  logic       clk;
  logic       reset;
  muldiv_op_t req_op;
  operand_t   req_a;
  operand_t   req_b;
  logic       req_val;
  logic       req_rdy;
  result_t    resp_result;
  logic       resp_val;
  logic       resp_rdy;

  integer seed = 32'hd463c458;

  // stimulus table, one entry per operation, expected value alongside
  muldiv_op_t tbl_op[$];
  operand_t   tbl_a[$];
  operand_t   tbl_b[$];
  result_t    tbl_exp[$];

  tb_clock_gen u_clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  imuldiv_muldiv u_imuldiv_muldiv (
    .clk         (clk),
    .reset       (reset),
    .req_op      (req_op),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  //--------------------------------------------------------------------------
  // reference model
  //--------------------------------------------------------------------------

  // mul gives the signed product, divides give {remainder, quotient}
  function automatic result_t model_result(muldiv_op_t op, operand_t a, operand_t b);
    longint   sa;
    longint   sb;
    operand_t quot;
    operand_t rem;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    if (op == op_mul) begin
      return result_t'(sa * sb);
    end
    if (b == '0) begin
      // divide by zero, all-ones quotient and the dividend back
      quot = '1;
      rem  = a;
    end else if (op == op_divu) begin
      quot = a / b;
      rem  = a % b;
    end else if ((a == 32'h8000_0000) && (b == '1)) begin
      // signed overflow
      quot = a;
      rem  = '0;
    end else begin
      // truncating division, remainder takes the dividend sign
      quot = operand_t'(sa / sb);
      rem  = operand_t'(sa % sb);
    end
    return {rem, quot};
  endfunction

  task automatic add_entry(input muldiv_op_t op, input operand_t a, input operand_t b);
    tbl_op.push_back(op);
    tbl_a.push_back(a);
    tbl_b.push_back(b);
    tbl_exp.push_back(model_result(op, a, b));
  endtask

  //--------------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------------

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_product(input result_t got, input result_t exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch at %0t: product got %h, expected %h", $time, got, exp));
    end
  endtask

  task automatic check_quot_rem(input result_t got, input result_t exp, input muldiv_op_t op);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch at %0t: %s rem/quot got %h/%h, expected %h/%h",
        $time, op.name(), got[63:32], got[31:0], exp[63:32], exp[31:0]));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_latency(input int got);
    if (got != resp_latency) begin
      fail_run($sformatf("Mismatch at %0t: resp_val rose after %0d edges, expected %0d",
        $time, got, resp_latency));
    end
  endtask

  task automatic compare_response(input muldiv_op_t op, input result_t exp);
    if (op == op_mul) begin
      check_product(resp_result, exp);
    end else begin
      check_quot_rem(resp_result, exp, op);
    end
  endtask

  //--------------------------------------------------------------------------
  // one request/response exchange
  //--------------------------------------------------------------------------

  task automatic run_entry(input int idx);
    int stall;
    int edges;
    bit seen;
    stall = {$random(seed)} % (max_stall + 1);
    @(posedge clk);
    req_op  <= tbl_op[idx];
    req_a   <= tbl_a[idx];
    req_b   <= tbl_b[idx];
    req_val <= 1'b1;
    // accept happens on the next edge once req_rdy is seen high
    seen = 1'b0;
    for (int i = 0; i < timeout_cycles && !seen; i++) begin
      @(negedge clk);
      if (req_rdy) begin
        seen = 1'b1;
      end
    end
    if (!seen) begin
      fail_run($sformatf("timeout: request %0d was never accepted", idx));
    end
    @(posedge clk);
    req_val <= 1'b0;
    // no stall, consumer is ready before the result shows up
    if (stall == 0) begin
      resp_rdy <= 1'b1;
    end
    edges = 1;
    seen  = 1'b0;
    for (int i = 0; i < timeout_cycles && !seen; i++) begin
      @(negedge clk);
      if (resp_val) begin
        seen = 1'b1;
      end else begin
        check_flag(req_rdy, 1'b0, "req_rdy while busy");
        @(posedge clk);
        edges++;
      end
    end
    if (!seen) begin
      fail_run($sformatf("timeout: response for request %0d never became valid", idx));
    end
    check_latency(edges);
    compare_response(tbl_op[idx], tbl_exp[idx]);
    // back-pressure, result and ready must hold
    for (int i = 1; i <= stall; i++) begin
      @(posedge clk);
      if (i == stall) begin
        resp_rdy <= 1'b1;
      end
      @(negedge clk);
      check_flag(resp_val, 1'b1, "resp_val under back-pressure");
      check_flag(req_rdy, 1'b0, "req_rdy under back-pressure");
      compare_response(tbl_op[idx], tbl_exp[idx]);
    end
    // response transfer edge
    @(posedge clk);
    resp_rdy <= 1'b0;
    @(negedge clk);
    check_flag(resp_val, 1'b0, "resp_val after transfer");
    check_flag(req_rdy, 1'b1, "req_rdy after transfer");
  endtask

  //--------------------------------------------------------------------------
  // main sequence
  //--------------------------------------------------------------------------

  initial begin
    muldiv_op_t op;
    operand_t   a;
    operand_t   b;
    bit         released;
    req_op   <= op_mul;
    req_a    <= '0;
    req_b    <= '0;
    req_val  <= 1'b0;
    resp_rdy <= 1'b0;

    // signed multiply, all sign combinations and extremes
    add_entry(op_mul, 32'd3, 32'd5);
    add_entry(op_mul, -32'sd3, 32'd5);
    add_entry(op_mul, 32'd3, -32'sd5);
    add_entry(op_mul, -32'sd3, -32'sd5);
    add_entry(op_mul, 32'h8000_0000, 32'h8000_0000);
    add_entry(op_mul, 32'h8000_0000, 32'hffff_ffff);
    add_entry(op_mul, 32'h8000_0000, 32'd1);
    add_entry(op_mul, 32'd0, -32'sd7);
    add_entry(op_mul, 32'h7fff_ffff, 32'h7fff_ffff);
    add_entry(op_mul, 32'hffff_ffff, 32'hffff_ffff);
    // signed divide, sign rules, overflow and zero divisor
    add_entry(op_div, 32'd7, 32'd2);
    add_entry(op_div, -32'sd7, 32'd2);
    add_entry(op_div, 32'd7, -32'sd2);
    add_entry(op_div, -32'sd7, -32'sd2);
    add_entry(op_div, 32'h8000_0000, 32'hffff_ffff);
    add_entry(op_div, 32'h8000_0000, 32'd2);
    add_entry(op_div, 32'd0, 32'd3);
    add_entry(op_div, 32'd5, 32'd0);
    add_entry(op_div, -32'sd5, 32'd0);
    // unsigned divide, top bit set means large positive
    add_entry(op_divu, 32'hffff_ffff, 32'd2);
    add_entry(op_divu, 32'h8000_0000, 32'd3);
    add_entry(op_divu, 32'd5, 32'hffff_ffff);
    add_entry(op_divu, 32'd100, 32'd7);
    add_entry(op_divu, 32'd7, 32'd0);
    add_entry(op_divu, 32'hffff_fff0, 32'd0);
    // random entries, some with small divisors for nonzero quotients
    for (int i = 0; i < random_entries; i++) begin
      op = muldiv_op_t'({$random(seed)} % 3);
      a  = $random(seed);
      b  = $random(seed);
      if ((i % 4) == 3) begin
        b = b & 32'h0000_00ff;
      end
      add_entry(op, a, b);
    end

    released = 1'b0;
    for (int i = 0; i < timeout_cycles && !released; i++) begin
      @(negedge clk);
      if (!reset) begin
        released = 1'b1;
      end
    end
    if (!released) begin
      fail_run("timeout: reset was never released");
    end
    check_flag(req_rdy, 1'b1, "req_rdy after reset");
    check_flag(resp_val, 1'b0, "resp_val after reset");

    for (int i = 0; i < tbl_op.size(); i++) begin
      run_entry(i);
    end

    $display("TEST OK");
    $finish;
  end

endmodule

// File: vlog.f
imuldiv_op_pkg.sv
imuldiv_ctrl_pkg.sv
imuldiv_mul_iterative.sv
imuldiv_div_iterative.sv
imuldiv_muldiv.sv
tb_clock_gen.sv
tb_imuldiv.sv
